/* design/kuz_pkg.sv */
package kuz_pkg;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Cipher dimensions.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  localparam int BLOCK_W = 128;       // Block and round key.
  localparam int KEY_W = 256;         // Master key.

  localparam int NUM_RKEYS = 10;
  localparam int NUM_KS_STEPS = 32;   // Feistel steps, 8 per key pair.

  localparam int RKEY_IDX_W = 4;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // FSM states.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  typedef enum logic {
    KS_IDLE,
    KS_EXPAND
  } ks_state_e;

  typedef enum logic {
    CORE_IDLE,
    CORE_RUN
  } core_state_e;

endpackage

/* design/kuz_sbox.sv */
module kuz_sbox (
  input  logic [7:0] byte_i,
  output logic [7:0] byte_o
);

  // One row of pi per high nibble, entry 0 in the top byte.
  logic [127:0] row;

  always_comb begin
    case (byte_i[7:4])
      4'h0: row = 128'hfceedd11cf6e3116fbc4fada23c5044d;
      4'h1: row = 128'he977f0db932e99ba1736f1bb14cd5fc1;
      4'h2: row = 128'hf918655ae25cef21811c3c428b018e4f;
      4'h3: row = 128'h058402aee36a8fa0060bed987fd4d31f;
      4'h4: row = 128'heb342c51eac848abf22a68a2fd3acecc;
      4'h5: row = 128'hb5700e56080c7612bf7213479cb75d87;
      4'h6: row = 128'h15a19629107b9ac7f391786f9d9eb2b1;
      4'h7: row = 128'h3275193dff358a7e6d54c680c3bd0d57;
      4'h8: row = 128'hdff524a93ea843c9d779d6f67c22b903;
      4'h9: row = 128'he00fecde7a94b0bcdce828504e330a4a;
      4'ha: row = 128'ha79760731e0062441ab83882649f2641;
      4'hb: row = 128'had454692275e552f8ca3a57d69d5953b;
      4'hc: row = 128'h0758b34086ac1df730376be488d9e789;
      4'hd: row = 128'he11b83494c3ff8fe8d53aa90cad88561;
      4'he: row = 128'h207167a42d2b095bcb9b25d0bee56c52;
      4'hf: row = 128'h59a674d2e6f4b4c0d166afc2394b63b6;
    endcase
  end

  // Low nibble picks the column, counted from the top byte.
  assign byte_o = row[{~byte_i[3:0], 3'b000} +: 8];

endmodule

/* design/kuz_lin.sv */
module kuz_lin (
  input  logic [kuz_pkg::BLOCK_W-1:0] data_i,
  output logic [kuz_pkg::BLOCK_W-1:0] data_o
);

  import kuz_pkg::*;

  localparam int NUM_BYTES = BLOCK_W / 8;

  // Weights for bytes 15 down to 0.
  localparam logic [7:0] LIN_COEF [NUM_BYTES] = '{
    8'd148, 8'd32, 8'd133, 8'd16, 8'd194, 8'd192, 8'd1, 8'd251,
    8'd1, 8'd192, 8'd194, 8'd16, 8'd133, 8'd32, 8'd148, 8'd1
  };

  // GF(2^8) product, modulus x^8 + x^7 + x^6 + x + 1.
  function automatic logic [7:0] gf_mul(input logic [7:0] a, input logic [7:0] b);
    logic [7:0] prod;
    logic [7:0] shf;
    prod = 8'h00;
    shf = a;
    for (int k = 0; k < 8; k++) begin
      if (b[k]) prod ^= shf;
      shf = {shf[6:0], 1'b0} ^ (shf[7] ? 8'hc3 : 8'h00);
    end
    return prod;
  endfunction

  logic [BLOCK_W-1:0] work;
  logic [7:0]         acc;

  // Sixteen R steps, fully unrolled.
  always_comb begin
    work = data_i;
    acc = 8'h00;
    for (int r = 0; r < NUM_BYTES; r++) begin
      acc = 8'h00;
      for (int i = 0; i < NUM_BYTES; i++) begin
        acc ^= gf_mul(LIN_COEF[i], work[BLOCK_W-1-8*i -: 8]);
      end
      work = {acc, work[BLOCK_W-1:8]};  // Sum enters at the top.
    end
    data_o = work;
  end

endmodule

/* design/kuz_round.sv */
module kuz_round (
  input  logic [kuz_pkg::BLOCK_W-1:0] state_i,
  input  logic [kuz_pkg::BLOCK_W-1:0] rkey_i,
  output logic [kuz_pkg::BLOCK_W-1:0] state_o
);

  import kuz_pkg::*;

  logic [BLOCK_W-1:0] mixed;
  logic [BLOCK_W-1:0] subst;

  assign mixed = state_i ^ rkey_i;  // X step.

  // S step, one table per byte.
  for (genvar g = 0; g < BLOCK_W / 8; g++) begin : g_sbox
    kuz_sbox u_sbox (
      .byte_i(mixed[8*g +: 8]),
      .byte_o(subst[8*g +: 8])
    );
  end

  kuz_lin u_lin (
    .data_i(subst),
    .data_o(state_o)
  );

endmodule

/* design/kuz_key_sched.sv */
module kuz_key_sched (
  input  logic                           clk_i,
  input  logic                           rst_i,
  input  logic                           load_i,
  input  logic [kuz_pkg::KEY_W-1:0]      key_i,
  input  logic [kuz_pkg::RKEY_IDX_W-1:0] rkey_idx_i,
  output logic [kuz_pkg::BLOCK_W-1:0]    round_key_o,
  output logic                           busy_o,
  output logic                           key_loaded_o
);

  import kuz_pkg::*;

  localparam int STEP_W = $clog2(NUM_KS_STEPS + 1);

  ks_state_e state_q;
  logic [STEP_W-1:0] step_q;  // Current step, 1 to 32.

  logic [BLOCK_W-1:0] a_q;
  logic [BLOCK_W-1:0] b_q;
  logic [BLOCK_W-1:0] const_w;
  logic [BLOCK_W-1:0] f_w;
  logic [BLOCK_W-1:0] a_next;

  logic [RKEY_IDX_W-1:0] wr_lo;
  logic [RKEY_IDX_W-1:0] wr_hi;

  logic [BLOCK_W-1:0] rkeys_q [NUM_RKEYS];

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Feistel step datapath.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  // Round constant C_j = L(j).
  kuz_lin u_const_lin (
    .data_i({{(BLOCK_W - STEP_W){1'b0}}, step_q}),
    .data_o(const_w)
  );

  kuz_round u_f_round (
    .state_i(a_q),
    .rkey_i (const_w),
    .state_o(f_w)
  );

  assign a_next = f_w ^ b_q;

  // Step 8k writes keys 2k and 2k+1.
  assign wr_lo = RKEY_IDX_W'({step_q[STEP_W-1:3], 1'b0});
  assign wr_hi = RKEY_IDX_W'({step_q[STEP_W-1:3], 1'b1});

  always_ff @(posedge clk_i) begin
    if (load_i) begin
      a_q <= key_i[KEY_W-1 -: BLOCK_W];
      b_q <= key_i[BLOCK_W-1:0];
      rkeys_q[0] <= key_i[KEY_W-1 -: BLOCK_W];
      rkeys_q[1] <= key_i[BLOCK_W-1:0];
    end else if (state_q == KS_EXPAND) begin
      a_q <= a_next;
      b_q <= a_q;
      if (step_q[2:0] == 3'd0) begin
        rkeys_q[wr_lo] <= a_next;
        rkeys_q[wr_hi] <= a_q;
      end
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Control.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_q <= KS_IDLE;
      step_q <= '0;
      key_loaded_o <= 1'b0;
    end else begin
      case (state_q)
        KS_IDLE: begin
          if (load_i) begin
            state_q <= KS_EXPAND;
            step_q <= STEP_W'(1);
            key_loaded_o <= 1'b0;  // Old keys are being overwritten.
          end
        end
        KS_EXPAND: begin
          if (step_q == STEP_W'(NUM_KS_STEPS)) begin
            state_q <= KS_IDLE;
            step_q <= '0;
            key_loaded_o <= 1'b1;
          end else begin
            step_q <= step_q + STEP_W'(1);
          end
        end
        default: state_q <= KS_IDLE;
      endcase
    end
  end

  assign busy_o = (state_q == KS_EXPAND);
  assign round_key_o = rkeys_q[rkey_idx_i];

  a_step_range: assert property (
    @(posedge clk_i) disable iff (rst_i)
    busy_o |-> (step_q != '0) && (step_q <= STEP_W'(NUM_KS_STEPS))
  ) else $error("key schedule step counter out of range");

endmodule

/* design/kuz_cipher_core.sv */
module kuz_cipher_core (
  input  logic                           clk_i,
  input  logic                           rst_i,
  input  logic                           start_i,
  input  logic [kuz_pkg::BLOCK_W-1:0]    blk_i,
  input  logic [kuz_pkg::BLOCK_W-1:0]    round_key_i,
  output logic [kuz_pkg::RKEY_IDX_W-1:0] rkey_idx_o,
  output logic                           busy_o,
  output logic                           ct_valid_o,
  output logic [kuz_pkg::BLOCK_W-1:0]    ct_o
);

  import kuz_pkg::*;

  localparam logic [RKEY_IDX_W-1:0] LAST_IDX = RKEY_IDX_W'(NUM_RKEYS - 1);

  core_state_e state_q;
  logic [RKEY_IDX_W-1:0] idx_q;
  logic [BLOCK_W-1:0] data_q;
  logic [BLOCK_W-1:0] round_w;
  logic last_w;

  kuz_round u_round (
    .state_i(data_q),
    .rkey_i (round_key_i),
    .state_o(round_w)
  );

  assign last_w = (state_q == CORE_RUN) && (idx_q == LAST_IDX);

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Round sequencing.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_q <= CORE_IDLE;
      idx_q <= '0;
    end else begin
      case (state_q)
        CORE_IDLE: begin
          if (start_i) begin
            state_q <= CORE_RUN;
            idx_q <= '0;
          end
        end
        CORE_RUN: begin
          if (last_w) begin
            state_q <= CORE_IDLE;  // Result shown this cycle.
            idx_q <= '0;
          end else begin
            idx_q <= idx_q + RKEY_IDX_W'(1);
          end
        end
        default: state_q <= CORE_IDLE;
      endcase
    end
  end

  // Rounds 0 to 8 go through XSL.
  always_ff @(posedge clk_i) begin
    if (start_i) begin
      data_q <= blk_i;
    end else if ((state_q == CORE_RUN) && !last_w) begin
      data_q <= round_w;
    end
  end

  assign rkey_idx_o = idx_q;
  assign busy_o = (state_q == CORE_RUN);
  assign ct_valid_o = last_w;
  assign ct_o = data_q ^ round_key_i;  // Final whitening with key 9.

  a_ct_single: assert property (
    @(posedge clk_i) disable iff (rst_i)
    ct_valid_o |=> !ct_valid_o
  ) else $error("ct_valid_o held for two cycles");

  a_no_start_busy: assert property (
    @(posedge clk_i) disable iff (rst_i)
    !(start_i && busy_o)
  ) else $error("block accepted while core busy");

endmodule

/* design/kuz_encrypt_top.sv */
module kuz_encrypt_top (
  input  logic                        clk_i,
  input  logic                        rst_i,
  input  logic                        key_valid_i,
  input  logic [kuz_pkg::KEY_W-1:0]   key_i,
  input  logic                        blk_valid_i,
  input  logic [kuz_pkg::BLOCK_W-1:0] blk_i,
  output logic                        ready_o,
  output logic                        key_loaded_o,
  output logic                        ct_valid_o,
  output logic [kuz_pkg::BLOCK_W-1:0] ct_o
);

  import kuz_pkg::*;

  logic ks_busy;
  logic core_busy;
  logic key_accept;
  logic blk_accept;

  logic [RKEY_IDX_W-1:0] rkey_idx;
  logic [BLOCK_W-1:0]    round_key;

  assign ready_o = !ks_busy && !core_busy;

  // Key wins over a block in the same cycle.
  assign key_accept = key_valid_i & ready_o;
  assign blk_accept = blk_valid_i & ready_o & key_loaded_o & ~key_valid_i;

  kuz_key_sched u_key_sched (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .load_i      (key_accept),
    .key_i       (key_i),
    .rkey_idx_i  (rkey_idx),
    .round_key_o (round_key),
    .busy_o      (ks_busy),
    .key_loaded_o(key_loaded_o)
  );

  kuz_cipher_core u_cipher_core (
    .clk_i      (clk_i),
    .rst_i      (rst_i),
    .start_i    (blk_accept),
    .blk_i      (blk_i),
    .round_key_i(round_key),
    .rkey_idx_o (rkey_idx),
    .busy_o     (core_busy),
    .ct_valid_o (ct_valid_o),
    .ct_o       (ct_o)
  );

endmodule

/* sim/kuz_ref_model.svh */
`ifndef KUZ_REF_MODEL_SVH
`define KUZ_REF_MODEL_SVH

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Reference model tables.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

// pi in 32-byte rows, lowest index in the top byte.
localparam logic [255:0] PI_ROWS [8] = '{
  256'hfceedd11cf6e3116fbc4fada23c5044de977f0db932e99ba1736f1bb14cd5fc1,
  256'hf918655ae25cef21811c3c428b018e4f058402aee36a8fa0060bed987fd4d31f,
  256'heb342c51eac848abf22a68a2fd3aceccb5700e56080c7612bf7213479cb75d87,
  256'h15a19629107b9ac7f391786f9d9eb2b13275193dff358a7e6d54c680c3bd0d57,
  256'hdff524a93ea843c9d779d6f67c22b903e00fecde7a94b0bcdce828504e330a4a,
  256'ha79760731e0062441ab83882649f2641ad454692275e552f8ca3a57d69d5953b,
  256'h0758b34086ac1df730376be488d9e789e11b83494c3ff8fe8d53aa90cad88561,
  256'h207167a42d2b095bcb9b25d0bee56c5259a674d2e6f4b4c0d166afc2394b63b6
};

// Weight of byte position 0 (lowest) up to 15.
localparam logic [7:0] L_WEIGHT [16] = '{
  8'd1, 8'd148, 8'd32, 8'd133, 8'd16, 8'd194, 8'd192, 8'd1,
  8'd251, 8'd1, 8'd192, 8'd194, 8'd16, 8'd133, 8'd32, 8'd148
};

logic [127:0] model_rk [10];  // Keys of the last accepted master key.

function automatic logic [7:0] ref_pi(input logic [7:0] x);
  logic [255:0] row;
  row = PI_ROWS[x[7:5]];
  return row[255 - 8 * int'(x[4:0]) -: 8];
endfunction

// Carry-less product, then reduce by 0x1c3 from the top bit down.
function automatic logic [7:0] ref_gmul(input logic [7:0] a, input logic [7:0] b);
  logic [14:0] p;
  p = '0;
  for (int i = 0; i < 8; i++) begin
    if (b[i]) p ^= 15'(a) << i;
  end
  for (int i = 14; i >= 8; i--) begin
    if (p[i]) p ^= 15'(9'h1c3) << (i - 8);
  end
  return p[7:0];
endfunction

function automatic logic [127:0] ref_lin(input logic [127:0] x);
  logic [127:0] s;
  logic [7:0]   t;
  s = x;
  for (int r = 0; r < 16; r++) begin
    t = 8'h00;
    for (int p = 0; p < 16; p++) t ^= ref_gmul(L_WEIGHT[p], s[8*p +: 8]);
    s = {t, s[127:8]};
  end
  return s;
endfunction

function automatic logic [127:0] ref_xsl(input logic [127:0] x, input logic [127:0] k);
  logic [127:0] s;
  s = x ^ k;
  for (int p = 0; p < 16; p++) s[8*p +: 8] = ref_pi(s[8*p +: 8]);
  return ref_lin(s);
endfunction

// Four groups of eight Feistel steps, constants C_j = L(j).
task automatic ref_expand(input logic [255:0] mkey);
  logic [127:0] a;
  logic [127:0] b;
  logic [127:0] t;
  a = mkey[255:128];
  b = mkey[127:0];
  model_rk[0] = a;
  model_rk[1] = b;
  for (int i = 0; i < 4; i++) begin
    for (int j = 1; j <= 8; j++) begin
      t = ref_xsl(a, ref_lin(128'(8 * i + j))) ^ b;
      b = a;
      a = t;
    end
    model_rk[2*i+2] = a;
    model_rk[2*i+3] = b;
  end
endtask

function automatic logic [127:0] ref_encrypt(input logic [127:0] pt);
  logic [127:0] s;
  s = pt;
  for (int r = 0; r < 9; r++) s = ref_xsl(s, model_rk[r]);
  return s ^ model_rk[9];
endfunction

`endif

/* sim/kuz_tb.sv */
module kuz_tb;

  import kuz_pkg::*;

  `include "kuz_ref_model.svh"

  localparam int CLK_PERIOD = 100;
  localparam int RESET_CYCLES = 10;
  localparam int NUM_RAND_KEYS = 20;
  localparam int BLKS_PER_KEY = 4;
  localparam int BURST_BLKS = 8;
  localparam int NUM_KEYS = NUM_RAND_KEYS + 2;
  localparam int NUM_BLOCKS = NUM_RAND_KEYS * BLKS_PER_KEY + BURST_BLKS + 3;
  localparam int WATCHDOG_CYCLES = NUM_KEYS * 40 + NUM_BLOCKS * 15 + 100;

  localparam logic [KEY_W-1:0] GOST_KEY =
    256'h8899aabbccddeeff0011223344556677fedcba98765432100123456789abcdef;
  localparam logic [BLOCK_W-1:0] GOST_PT = 128'h1122334455667700ffeeddccbbaa9988;
  localparam logic [BLOCK_W-1:0] GOST_CT = 128'h7f679d90bebc24305a468d42b9d4edcd;

  logic clk;
  logic rst;
  logic key_valid;
  logic [KEY_W-1:0] key;
  logic blk_valid;
  logic [BLOCK_W-1:0] blk;
  logic ready;
  logic key_loaded;
  logic ct_valid;
  logic [BLOCK_W-1:0] ct;

  logic [BLOCK_W-1:0] exp_ct_q [$];
  int exp_cyc_q [$];
  logic [BLOCK_W-1:0] mon_exp;
  int mon_cyc;
  int cyc = 0;
  int mismatch_cnt = 0;
  int fail_cnt = 0;
  int unsigned first_draw;
  logic key_taken;

  kuz_encrypt_top u_dut (
    .clk_i       (clk),
    .rst_i       (rst),
    .key_valid_i (key_valid),
    .key_i       (key),
    .blk_valid_i (blk_valid),
    .blk_i       (blk),
    .ready_o     (ready),
    .key_loaded_o(key_loaded),
    .ct_valid_o  (ct_valid),
    .ct_o        (ct)
  );

  initial clk = 1'b0;
  always #(CLK_PERIOD / 2) clk = ~clk;

  always @(posedge clk) cyc <= cyc + 1;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Result monitor.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  always @(negedge clk) begin
    if (!rst && ct_valid) begin
      if (exp_ct_q.size() == 0) begin
        $display("ERROR: result at time %0t with no accepted block", $time);
        fail_cnt++;
      end else begin
        mon_exp = exp_ct_q.pop_front();
        mon_cyc = exp_cyc_q.pop_front();
        if (ct !== mon_exp) begin
          $display("MISMATCH at time %0t: ct_o %h, expected %h", $time, ct, mon_exp);
          mismatch_cnt++;
        end
        if (cyc != mon_cyc) begin
          $display("MISMATCH at time %0t: result in cycle %0d, expected %0d",
                   $time, cyc, mon_cyc);
          mismatch_cnt++;
        end
      end
    end
  end

  function automatic logic [BLOCK_W-1:0] rand_block();
    return {$urandom, $urandom, $urandom, $urandom};
  endfunction

  // Acceptance follows the handshake rules, seen at the driving edge.
  task automatic drive_strobes(input logic kv, input logic [KEY_W-1:0] k,
                               input logic bv, input logic [BLOCK_W-1:0] b);
    logic blk_acc;
    key_valid = kv;
    key = k;
    blk_valid = bv;
    blk = b;
    key_taken = kv && ready;
    blk_acc = bv && ready && key_loaded && !kv;
    if (key_taken) ref_expand(k);
    if (blk_acc) begin
      exp_ct_q.push_back(ref_encrypt(b));
      exp_cyc_q.push_back(cyc + 10);  // Accept edge counts as the first.
    end
    @(negedge clk);
    key_valid = 1'b0;
    blk_valid = 1'b0;
    if ((key_taken || blk_acc) && ready) begin
      $display("ERROR: ready_o still high after an accepted strobe at %0t", $time);
      fail_cnt++;
    end
  endtask

  task automatic wait_key_loaded();
    int edges;
    edges = 0;
    while (!key_loaded && edges < 64) begin
      @(negedge clk);
      edges++;
    end
    if (edges != NUM_KS_STEPS) begin
      $display("MISMATCH at time %0t: key loaded after %0d edges", $time, edges);
      mismatch_cnt++;
    end
  endtask

  task automatic load_key(input logic [KEY_W-1:0] k);
    while (!ready) @(negedge clk);
    drive_strobes(1'b1, k, 1'b0, '0);
    wait_key_loaded();
  endtask

  task automatic send_block(input logic [BLOCK_W-1:0] b);
    while (!(ready && key_loaded)) @(negedge clk);
    drive_strobes(1'b0, '0, 1'b1, b);
    if (!ready && ($urandom % 2 == 1)) begin
      drive_strobes(1'b1, {rand_block(), rand_block()}, 1'b1, rand_block());  // Busy.
    end
  endtask

  initial begin
    first_draw = $urandom(32'h34dc);
    rst = 1'b1;
    key_valid = 1'b0;
    key = '0;
    blk_valid = 1'b0;
    blk = '0;
    repeat (RESET_CYCLES) @(negedge clk);
    rst = 1'b0;
    @(negedge clk);
    if (!ready || key_loaded || ct_valid) begin
      $display("ERROR: outputs after reset are not idle");
      fail_cnt++;
    end

    ref_expand(GOST_KEY);
    if (ref_encrypt(GOST_PT) !== GOST_CT) begin
      $display("MISMATCH at time %0t: model misses the standard vector", $time);
      mismatch_cnt++;
    end

    drive_strobes(1'b0, '0, 1'b1, rand_block());  // No key loaded yet.
    repeat (12) @(negedge clk);
    load_key(GOST_KEY);
    send_block(GOST_PT);

    for (int k = 0; k < NUM_RAND_KEYS; k++) begin
      load_key({rand_block(), rand_block()});
      for (int n = 0; n < BLKS_PER_KEY; n++) send_block(rand_block());
    end

    // Key and block together, the block is dropped.
    while (!(ready && key_loaded)) @(negedge clk);
    drive_strobes(1'b1, {rand_block(), rand_block()}, 1'b1, rand_block());
    wait_key_loaded();

    for (int n = 0; n < BURST_BLKS; n++) send_block(rand_block());
    while (exp_ct_q.size() != 0) @(negedge clk);
    repeat (12) @(negedge clk);

    $display("Errors: %0d mismatches, %0d other failures", mismatch_cnt, fail_cnt);
    if (mismatch_cnt == 0 && fail_cnt == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

  initial begin
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    $display("ERROR: watchdog expired after %0d cycles", WATCHDOG_CYCLES);
    $display("Test FAILED");
    $finish;
  end

endmodule

/* kuz_encrypt_top.f */
+incdir+sim
design/kuz_pkg.sv
design/kuz_sbox.sv
design/kuz_lin.sv
design/kuz_round.sv
design/kuz_key_sched.sv
design/kuz_cipher_core.sv
design/kuz_encrypt_top.sv
sim/kuz_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the Kuznechik testbench with Verilator.
# Exit status is 0 only if the run printed the pass line.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
  --top-module kuz_tb -f kuz_encrypt_top.f -o kuz_tb_sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

sim_out=$(./obj_dir/kuz_tb_sim 2>&1)
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
  echo "Simulation exited with status $sim_status"
  exit 1
fi

if echo "$sim_out" | grep -qx "Test OK"; then
  exit 0
fi
exit 1
